/* apb_pkg.sv */
//////////////////////////////////////////////////////////////////////
// APB bus types and register map of the stroke capture block.
//////////////////////////////////////////////////////////////////////

package apb_pkg;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Control, bit 0 acknowledges a finished capture.
    localparam apb_addr_t REG_CTRL   = 12'h000;

    // Done flag, latched cell and capture state.
    localparam apb_addr_t REG_STATUS = 12'h004;

    // Idle limit in clock cycles.
    localparam apb_addr_t REG_IDLE   = 12'h008;

    // First track word, word k sits at REG_TRACK0 + 4k.
    localparam apb_addr_t REG_TRACK0 = 12'h100;

endpackage

/* apb_regs.sv */
//////////////////////////////////////////////////////////////////////
// APB register slave.
// Control, status and idle limit registers plus readout of the
// captured track, zero wait states.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "draw_defines.svh"

module apb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  apb_pkg::apb_addr_t       paddr,
    input  apb_pkg::apb_data_t       pwdata,
    output apb_pkg::apb_data_t       prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     done,
    input  draw_pkg::cell_idx_t      cap_x,
    input  draw_pkg::cell_idx_t      cap_y,
    input  draw_pkg::capture_state_t state,
    input  draw_pkg::track_t         track,
    output logic                     ack,
    output draw_pkg::cycle_cnt_t     idle_limit
);

    logic                           access;
    logic                           aligned;
    logic                           is_ctrl;
    logic                           is_status;
    logic                           is_idle;
    logic                           is_track;
    logic                           mapped;
    apb_pkg::apb_addr_t             track_off;
    logic [6:0]                     track_word;
    logic [`TRACK_WORDS*32-1:0]     track_pad;
    apb_pkg::apb_data_t             status_word;

    // Access phase of a transfer.
    assign access = psel && penable;

    assign aligned   = (paddr[1:0] == 2'b00);
    assign is_ctrl   = (paddr == apb_pkg::REG_CTRL);
    assign is_status = (paddr == apb_pkg::REG_STATUS);
    assign is_idle   = (paddr == apb_pkg::REG_IDLE);
    assign is_track  = aligned
                    && (paddr >= apb_pkg::REG_TRACK0)
                    && (paddr < apb_pkg::REG_TRACK0 + apb_pkg::apb_addr_t'(4 * `TRACK_WORDS));
    assign mapped    = is_ctrl || is_status || is_idle || is_track;

    assign track_off  = paddr - apb_pkg::REG_TRACK0;
    assign track_word = track_off[8:2];

    // Top bits of the last word read as zero.
    assign track_pad = {{(`TRACK_WORDS*32 - `TRACK_BITS){1'b0}}, track};

    assign status_word = {18'b0, state, cap_y, cap_x, 3'b000, done};

    assign pready = 1'b1;

    // Status and track are read only.
    assign pslverr = access && (!mapped || (pwrite && (is_status || is_track)));

    always_comb begin
        prdata = '0;
        if (is_status) begin
            prdata = status_word;
        end else if (is_idle) begin
            prdata = idle_limit;
        end else if (is_track) begin
            prdata = track_pad[track_word*32 +: 32];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_limit <= `IDLE_LIMIT_RST;
            ack        <= 1'b0;
        end else begin
            // Single cycle pulse per write of 1 to ctrl bit 0.
            ack <= access && pwrite && is_ctrl && pwdata[0];
            if (access && pwrite && is_idle) begin
                idle_limit <= pwdata;
            end
        end
    end

endmodule

/* cell_locate.sv */
//////////////////////////////////////////////////////////////////////
// Cell locator.
// Mirrors the mouse position and splits it into a cell index and
// an offset inside the cell pitch, all registered.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "draw_defines.svh"

module cell_locate (
    input  logic                clk,
    input  logic                rst,
    input  draw_pkg::coord_t    mouse_x,
    input  draw_pkg::coord_t    mouse_y,
    output draw_pkg::cell_idx_t cell_x,
    output draw_pkg::cell_idx_t cell_y,
    output draw_pkg::coord_t    off_x,
    output draw_pkg::coord_t    off_y,
    output logic                on_board,
    output logic                in_cell
);

    logic [10:0]         rel_x;
    logic [10:0]         rel_y;
    draw_pkg::cell_idx_t idx_x;
    draw_pkg::cell_idx_t idx_y;
    draw_pkg::coord_t    rem_x;
    draw_pkg::coord_t    rem_y;
    logic                hit_board;

    // Divide by the pitch with a compare chain over its multiples.
    function automatic draw_pkg::cell_idx_t pitch_index(input draw_pkg::coord_t r);
        draw_pkg::cell_idx_t idx;
        idx = '0;
        for (int k = 1; k < `GRID_N; k++) begin
            if (r >= draw_pkg::coord_t'(k * `CELL_PITCH)) begin
                idx = draw_pkg::cell_idx_t'(k);
            end
        end
        return idx;
    endfunction

    // Mirrored position relative to the board origin, bit 10 flags negative.
    assign rel_x = {1'b0, draw_pkg::coord_t'(`SCREEN_W - 1) - mouse_x} - 11'(`BOARD_X0);
    assign rel_y = {1'b0, draw_pkg::coord_t'(`SCREEN_H - 1) - mouse_y} - 11'(`BOARD_Y0);

    assign idx_x = pitch_index(rel_x[9:0]);
    assign idx_y = pitch_index(rel_y[9:0]);
    assign rem_x = rel_x[9:0] - draw_pkg::coord_t'(idx_x * `CELL_PITCH);
    assign rem_y = rel_y[9:0] - draw_pkg::coord_t'(idx_y * `CELL_PITCH);

    assign hit_board = !rel_x[10] && !rel_y[10]
                    && (rel_x[9:0] < draw_pkg::coord_t'(`GRID_N * `CELL_PITCH))
                    && (rel_y[9:0] < draw_pkg::coord_t'(`GRID_N * `CELL_PITCH));

    always_ff @(posedge clk) begin
        if (rst) begin
            cell_x   <= '0;
            cell_y   <= '0;
            off_x    <= '0;
            off_y    <= '0;
            on_board <= 1'b0;
            in_cell  <= 1'b0;
        end else begin
            cell_x   <= idx_x;
            cell_y   <= idx_y;
            off_x    <= rem_x;
            off_y    <= rem_y;
            on_board <= hit_board;
            // The last 2 pixels of each pitch are the gap.
            in_cell  <= hit_board
                     && (rem_x < draw_pkg::coord_t'(`CELL_SIZE))
                     && (rem_y < draw_pkg::coord_t'(`CELL_SIZE));
        end
    end

endmodule

/* draw_defines.svh */
//////////////////////////////////////////////////////////////////////
// Drawing board geometry and capture defaults.
// Screen size, board origin, cell pitch and track sizing.
//////////////////////////////////////////////////////////////////////

`ifndef DRAW_DEFINES_SVH
`define DRAW_DEFINES_SVH

// Screen size in pixels.
`define SCREEN_W 640
`define SCREEN_H 480

// Board origin in mirrored coordinates.
`define BOARD_X0 160
`define BOARD_Y0 0

// Each pitch holds a cell and a 2 pixel gap.
`define CELL_SIZE 52
`define CELL_PITCH 54

// Board is GRID_N cells on each side.
`define GRID_N 9

// Track bitmap, CELL_SIZE squared, packed into 32-bit words.
`define TRACK_BITS 2704
`define TRACK_WORDS 85

// Button-up cycles before a capture ends.
`define IDLE_LIMIT_RST 32'd50_000_000

`endif

/* draw_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Drawing types shared by the locate and capture blocks.
//////////////////////////////////////////////////////////////////////

`include "draw_defines.svh"

package draw_pkg;

    // Screen coordinate, raw or mirrored.
    typedef logic [9:0] coord_t;

    // Row or column of a board cell.
    typedef logic [3:0] cell_idx_t;

    // Bit position inside the track bitmap.
    typedef logic [11:0] track_idx_t;

    // One bit per pixel of a cell.
    typedef logic [`TRACK_BITS-1:0] track_t;

    typedef logic [31:0] cycle_cnt_t;

    typedef enum logic [1:0] {
        CAP_WAIT = 2'd0,
        CAP_DRAW = 2'd1,
        CAP_DONE = 2'd2
    } capture_state_t;

endpackage

/* mouse_draw_assert.sv */
//////////////////////////////////////////////////////////////////////
// Protocol checks on the APB slave and the capture handshake.
// Bound into the register block, which sees both sides.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_draw_assert (
    input logic             clk,
    input logic             rst,
    input logic             psel,
    input logic             penable,
    input logic             pslverr,
    input logic             done,
    input logic             ack,
    input draw_pkg::track_t track
);

    // Error response only in the access cycle that follows a setup cycle.
    a_pslverr_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable && $past(psel && !penable))
        else $error("pslverr outside an APB access cycle");

    // A finished capture waits for the host.
    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        done && !ack |=> done)
        else $error("done fell without an ack");

    a_track_hold: assert property (@(posedge clk) disable iff (rst)
        done |=> $stable(track))
        else $error("track changed while done was high");

endmodule

bind apb_regs mouse_draw_assert i_mouse_draw_assert (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .done    (done),
    .ack     (ack),
    .track   (track)
);

/* mouse_draw_top.sv */
//////////////////////////////////////////////////////////////////////
// Mouse stroke capture top level.
// Cell locator, capture FSM and APB registers.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_draw_top (
    input  logic               clk,
    input  logic               rst,
    input  draw_pkg::coord_t   mouse_x,
    input  draw_pkg::coord_t   mouse_y,
    input  logic               mouse_left,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               irq
);

    draw_pkg::cell_idx_t      cell_x;
    draw_pkg::cell_idx_t      cell_y;
    draw_pkg::coord_t         off_x;
    draw_pkg::coord_t         off_y;
    logic                     on_board;
    logic                     in_cell;
    draw_pkg::capture_state_t state;
    logic                     done;
    draw_pkg::cell_idx_t      cap_x;
    draw_pkg::cell_idx_t      cap_y;
    draw_pkg::track_t         track;
    logic                     ack;
    draw_pkg::cycle_cnt_t     idle_limit;

    cell_locate i_cell_locate (
        .clk      (clk),
        .rst      (rst),
        .mouse_x  (mouse_x),
        .mouse_y  (mouse_y),
        .cell_x   (cell_x),
        .cell_y   (cell_y),
        .off_x    (off_x),
        .off_y    (off_y),
        .on_board (on_board),
        .in_cell  (in_cell)
    );

    stroke_capture i_stroke_capture (
        .clk        (clk),
        .rst        (rst),
        .mouse_left (mouse_left),
        .cell_x     (cell_x),
        .cell_y     (cell_y),
        .off_x      (off_x),
        .off_y      (off_y),
        .on_board   (on_board),
        .in_cell    (in_cell),
        .ack        (ack),
        .idle_limit (idle_limit),
        .state      (state),
        .done       (done),
        .cap_x      (cap_x),
        .cap_y      (cap_y),
        .track      (track)
    );

    apb_regs i_apb_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .done       (done),
        .cap_x      (cap_x),
        .cap_y      (cap_y),
        .state      (state),
        .track      (track),
        .ack        (ack),
        .idle_limit (idle_limit)
    );

    // Interrupt level follows the finished capture.
    assign irq = done;

endmodule

/* project.f */
+incdir+.
draw_pkg.sv
apb_pkg.sv
cell_locate.sv
stroke_capture.sv
apb_regs.sv
mouse_draw_top.sv
mouse_draw_assert.sv
tb_mouse_draw.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the mouse draw testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mouse_draw -f project.f -o sim_mouse_draw

# Pass only when the pass line shows up in the simulation output.
./obj_dir/sim_mouse_draw | tee /dev/stderr | grep -x "sim passed" > /dev/null

/* stroke_capture.sv */
//////////////////////////////////////////////////////////////////////
// Stroke capture.
// Latches the pressed cell, records pressed pixels into the track
// bitmap and ends the capture after a run of button-up cycles.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "draw_defines.svh"

module stroke_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mouse_left,
    input  draw_pkg::cell_idx_t      cell_x,
    input  draw_pkg::cell_idx_t      cell_y,
    input  draw_pkg::coord_t         off_x,
    input  draw_pkg::coord_t         off_y,
    input  logic                     on_board,
    input  logic                     in_cell,
    input  logic                     ack,
    input  draw_pkg::cycle_cnt_t     idle_limit,
    output draw_pkg::capture_state_t state,
    output logic                     done,
    output draw_pkg::cell_idx_t      cap_x,
    output draw_pkg::cell_idx_t      cap_y,
    output draw_pkg::track_t         track
);

    logic                 btn_q;
    logic                 btn_qq;
    logic                 release_edge;
    logic                 start;
    logic                 hit_cell;
    logic                 idle_end;
    draw_pkg::cycle_cnt_t idle_cnt;
    draw_pkg::track_idx_t bit_idx;

    // Button delayed to line up with the registered position.
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q  <= 1'b0;
            btn_qq <= 1'b0;
        end else begin
            btn_q  <= mouse_left;
            btn_qq <= btn_q;
        end
    end

    assign release_edge = btn_qq && !btn_q;

    assign start = (state == draw_pkg::CAP_WAIT) && btn_q && on_board;

    // Only pixels inside the latched cell count.
    assign hit_cell = btn_q && in_cell && (cell_x == cap_x) && (cell_y == cap_y);

    assign bit_idx = draw_pkg::track_idx_t'(off_y * `CELL_SIZE + off_x);

    // A count of zero means the idle counter is not running.
    // Compare with >= so a limit lowered mid-count still ends the capture.
    assign idle_end = !btn_q && (idle_cnt != '0) && (idle_cnt >= idle_limit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= draw_pkg::CAP_WAIT;
            cap_x <= '0;
            cap_y <= '0;
        end else begin
            case (state)
                draw_pkg::CAP_WAIT: begin
                    if (start) begin
                        state <= draw_pkg::CAP_DRAW;
                        cap_x <= cell_x;
                        cap_y <= cell_y;
                    end
                end
                draw_pkg::CAP_DRAW: begin
                    if (idle_end) begin
                        state <= draw_pkg::CAP_DONE;
                    end
                end
                draw_pkg::CAP_DONE: begin
                    // Cell and track are held until the host acknowledges.
                    if (ack) begin
                        state <= draw_pkg::CAP_WAIT;
                    end
                end
                default: state <= draw_pkg::CAP_WAIT;
            endcase
        end
    end

    // Idle counter, restarted by any new press.
    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if (state != draw_pkg::CAP_DRAW || btn_q || idle_end) begin
            idle_cnt <= '0;
        end else if (release_edge) begin
            idle_cnt <= 32'd1;
        end else if (idle_cnt != '0) begin
            idle_cnt <= idle_cnt + 32'd1;
        end
    end

    // Track bitmap.
    always_ff @(posedge clk) begin
        if (start) begin
            track <= '0;
        end else if (state == draw_pkg::CAP_DRAW && hit_cell) begin
            track[bit_idx] <= 1'b1;
        end
    end

    assign done = (state == draw_pkg::CAP_DONE);

endmodule

/* tb_mouse_draw.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the mouse stroke capture top level.
// Directed mouse and APB tests checked against a track bitmap model.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "draw_defines.svh"

module tb_mouse_draw;

    localparam int TEST_COUNT = 6;

    logic clk, rst, mouse_left, psel, penable, pwrite, pready, pslverr, irq;
    draw_pkg::coord_t   mouse_x, mouse_y;
    apb_pkg::apb_addr_t paddr;
    apb_pkg::apb_data_t pwdata, prdata;

    int errors, failed, exp_cx, exp_cy;
    logic [31:0] lfsr;
    logic [`TRACK_WORDS*32-1:0] model;

    mouse_draw_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog allows 20 us per test.
    initial begin
        #(TEST_COUNT * 20000);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("sim failed");
        $finish;
    end

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic wrong_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    // Setup cycle, then access cycle until pready.
    task automatic apb_transfer(input logic wr, input apb_pkg::apb_addr_t addr,
                                input apb_pkg::apb_data_t wdata,
                                output apb_pkg::apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                             output logic err);
        apb_pkg::apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    // Takes mirrored coordinates and drives the raw mouse position.
    task automatic mouse_move(input int mx, input int my, input logic pressed);
        int rx, ry;
        logic [11:0] bit_n;
        @(negedge clk);
        mouse_x    = draw_pkg::coord_t'(`SCREEN_W - 1 - mx);
        mouse_y    = draw_pkg::coord_t'(`SCREEN_H - 1 - my);
        mouse_left = pressed;
        repeat (3) @(posedge clk);
        rx = mx - `BOARD_X0;
        ry = my - `BOARD_Y0;
        // Model records pressed pixels of the latched cell, gap excluded.
        if (pressed && rx >= 0 && ry >= 0 && rx / `CELL_PITCH == exp_cx
                && ry / `CELL_PITCH == exp_cy && rx % `CELL_PITCH < `CELL_SIZE
                && ry % `CELL_PITCH < `CELL_SIZE) begin
            bit_n = 12'((ry % `CELL_PITCH) * `CELL_SIZE + rx % `CELL_PITCH);
            model[bit_n] = 1'b1;
        end
    endtask

    task automatic cell_pixel(input int cx, input int cy, input int ox, input int oy);
        mouse_move(`BOARD_X0 + cx * `CELL_PITCH + ox, `BOARD_Y0 + cy * `CELL_PITCH + oy, 1'b1);
    endtask

    task automatic random_stroke(input int cx, input int cy, input int points);
        for (int i = 0; i < points; i++) begin
            cell_pixel(cx, cy, int'(rand_bits(6)) % `CELL_SIZE, int'(rand_bits(6)) % `CELL_SIZE);
        end
    endtask

    // Release, wait for irq, then check status and every track word.
    task automatic finish_capture();
        apb_pkg::apb_data_t d, want;
        logic e;
        logic [11:0] base;
        int n;
        mouse_move(0, 0, 1'b0);
        n = 0;
        while (irq !== 1'b1 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            $display("Error at %0t ns: irq did not rise after the button was released", $time);
            errors++;
        end
        apb_read(apb_pkg::REG_STATUS, d, e);
        want = 1 + exp_cx * 16 + exp_cy * 256 + 2 * 4096;
        if (d !== want) begin
            wrong_value("status after capture", d, want);
        end
        for (int k = 0; k < `TRACK_WORDS; k++) begin
            base = 12'(k * 32);
            apb_read(apb_pkg::REG_TRACK0 + apb_pkg::apb_addr_t'(4 * k), d, e);
            if (d !== model[base +: 32]) begin
                wrong_value($sformatf("track word %0d", k), d, model[base +: 32]);
            end
        end
    endtask

    task automatic check_reset_values();
        apb_pkg::apb_data_t d;
        logic e;
        apb_read(apb_pkg::REG_STATUS, d, e);
        if (d !== 32'd0) begin
            wrong_value("status after reset", d, 32'd0);
        end
        apb_read(apb_pkg::REG_IDLE, d, e);
        if (d !== `IDLE_LIMIT_RST) begin
            wrong_value("idle limit after reset", d, `IDLE_LIMIT_RST);
        end
        if (irq !== 1'b0) begin
            wrong_value("irq after reset", {31'b0, irq}, 32'd0);
        end
        // Short idle limit so captures end quickly.
        apb_write(apb_pkg::REG_IDLE, 32'd20, e);
    endtask

    task automatic ignore_off_board_press();
        apb_pkg::apb_data_t d;
        logic e;
        exp_cx = -1;
        for (int i = 0; i < 4; i++) begin
            mouse_move(int'(rand_bits(7)), int'(rand_bits(8)), 1'b1);
        end
        mouse_move(0, 0, 1'b0);
        repeat (40) @(negedge clk);
        apb_read(apb_pkg::REG_STATUS, d, e);
        if (d !== 32'd0) begin
            wrong_value("status after off-board press", d, 32'd0);
        end
        if (irq !== 1'b0) begin
            wrong_value("irq after off-board press", {31'b0, irq}, 32'd0);
        end
    endtask

    task automatic capture_one_stroke();
        exp_cx = int'(rand_bits(3));
        exp_cy = int'(rand_bits(3));
        model  = '0;
        random_stroke(exp_cx, exp_cy, 12);
        finish_capture();
    endtask

    task automatic restart_after_ack();
        apb_pkg::apb_data_t d;
        logic e;
        apb_write(apb_pkg::REG_CTRL, 32'd1, e);
        apb_read(apb_pkg::REG_STATUS, d, e);
        if ((d & 32'h0000_3001) !== 32'd0) begin
            wrong_value("done and state after ack", d & 32'h0000_3001, 32'd0);
        end
        if (irq !== 1'b0) begin
            wrong_value("irq after ack", {31'b0, irq}, 32'd0);
        end
        exp_cx = int'(rand_bits(3));
        exp_cy = int'(rand_bits(3));
        model  = '0;
        random_stroke(exp_cx, exp_cy, 5);
        finish_capture();
        apb_write(apb_pkg::REG_CTRL, 32'd1, e);
    endtask

    task automatic merge_second_press();
        apb_pkg::apb_data_t d, want;
        logic e;
        exp_cx = int'(rand_bits(3)) % 7;
        exp_cy = int'(rand_bits(3)) % 7;
        model  = '0;
        cell_pixel(exp_cx, exp_cy, 10, 20);
        // Gap column, gap row, then the cells to the right and below.
        cell_pixel(exp_cx, exp_cy, 52, 21);
        cell_pixel(exp_cx, exp_cy, 11, 53);
        cell_pixel(exp_cx + 1, exp_cy, 30, 40);
        cell_pixel(exp_cx, exp_cy + 1, 40, 30);
        random_stroke(exp_cx, exp_cy, 4);
        mouse_move(0, 0, 1'b0);
        apb_read(apb_pkg::REG_STATUS, d, e);
        want = exp_cx * 16 + exp_cy * 256 + 4096;
        if (d !== want) begin
            wrong_value("status between presses", d, want);
        end
        random_stroke(exp_cx, exp_cy, 4);
        finish_capture();
        apb_write(apb_pkg::REG_CTRL, 32'd1, e);
    endtask

    task automatic flag_bus_errors();
        apb_pkg::apb_data_t d, want;
        logic e;
        apb_read(12'h00C, d, e);
        if (e !== 1'b1) begin
            $display("Error at %0t ns: no pslverr on a read of an unmapped address", $time);
            errors++;
        end
        apb_write(apb_pkg::REG_STATUS, 32'hFFFF_FFFF, e);
        if (e !== 1'b1) begin
            $display("Error at %0t ns: no pslverr on a write to the status register", $time);
            errors++;
        end
        // Cell stays latched after the ack and the state is back in wait.
        apb_read(apb_pkg::REG_STATUS, d, e);
        want = exp_cx * 16 + exp_cy * 256;
        if (d !== want) begin
            wrong_value("status after rejected write", d, want);
        end
        if (e !== 1'b0) begin
            $display("Error at %0t ns: pslverr on a read of the status register", $time);
            errors++;
        end
        apb_read(apb_pkg::REG_IDLE, d, e);
        if (d !== 32'd20) begin
            wrong_value("idle limit after rejected write", d, 32'd20);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            failed++;
        end
    endtask

    initial begin
        int mark;
        rst        = 1'b1;
        mouse_x    = '0;
        mouse_y    = '0;
        mouse_left = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        errors     = 0;
        failed     = 0;
        exp_cx     = 0;
        exp_cy     = 0;
        model      = '0;
        lfsr       = 32'd94849;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mark = errors;
        check_reset_values();
        end_test("reset values", mark);
        mark = errors;
        ignore_off_board_press();
        end_test("off-board press", mark);
        mark = errors;
        capture_one_stroke();
        end_test("single stroke", mark);
        mark = errors;
        restart_after_ack();
        end_test("ack and restart", mark);
        mark = errors;
        merge_second_press();
        end_test("gap and second press", mark);
        mark = errors;
        flag_bus_errors();
        end_test("bus errors", mark);

        $display("tests run %0d, tests failed %0d, errors %0d", TEST_COUNT, failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
